// File: hdl/crc24_pkg.sv
`default_nettype none

package crc24_pkg;

    ///////////////////////////////
    // widths and limits
    ///////////////////////////////
    localparam int CRC_W     = 24;
    localparam int WORD_W    = 64;
    localparam int MAX_WORDS = 6;

    // crc state or evolved word
    typedef logic [CRC_W-1:0]  crc_t;
    // one data word of a burst
    typedef logic [WORD_W-1:0] data_word_t;
    // words preceding the newest one, 0 to 5
    typedef logic [2:0]        cover_t;

    // generator 0x328B63 without its top bit
    localparam crc_t CRC_POLY = 24'h328B63;
    // start value of every burst
    localparam crc_t CRC_INIT = 24'hFFFFFF;

    // four-phase word handshake on the input side
    typedef enum logic [1:0] {in_idle, in_acked, in_blocked} intake_state_t;
    // result handshake on the output side
    typedef enum logic [1:0] {res_empty, res_offered, res_taken} result_state_t;

    // one step of the crc24 register, msb first, no reflection
    function automatic crc_t crc_shift(crc_t s, logic b);
        logic fb;
        fb = s[CRC_W-1] ^ b;
        return {s[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : crc_t'(0));
    endfunction

endpackage

`default_nettype wire

// File: hdl/crc_window_if.sv
`timescale 1ns/1ns
`default_nettype none

interface crc_window_if;

    // pulses once per burst, when the last word is in the window
    logic                valid;
    // how many older words belong to this burst
    crc24_pkg::cover_t   covered;
    // evolved words, index 0 newest, index k is k places older
    crc24_pkg::crc_t     evo [crc24_pkg::MAX_WORDS];

    // evolver side
    modport producer (
        output valid,
        output covered,
        output evo
    );

    // combiner side
    modport consumer (
        input valid,
        input covered,
        input evo
    );

endinterface

`default_nettype wire

// File: hdl/crc24_zero_advance.sv
`timescale 1ns/1ns
`default_nettype none

module crc24_zero_advance #(
    // number of all-zero 64-bit words, 1 to 6
    parameter int WORDS = 1
) (
    input  wire crc24_pkg::crc_t state_in,
    output crc24_pkg::crc_t      state_out
);

    localparam int BITS = WORDS * crc24_pkg::WORD_W;

    crc24_pkg::crc_t s;

    ///////////////////////////////
    // zero-data advance
    ///////////////////////////////
    // linear in state_in, so this folds into a xor matrix
    always_comb begin
        s = state_in;
        for (int i = 0; i < BITS; i++) begin
            s = crc24_pkg::crc_shift(s, 1'b0);
        end
    end

    assign state_out = s;

endmodule

`default_nettype wire

// File: hdl/burst_intake.sv
`timescale 1ns/1ns
`default_nettype none

module burst_intake (
    input  wire logic                  clk,
    input  wire logic                  arst,
    input  wire logic                  word_req,
    input  wire crc24_pkg::data_word_t word_data_in,
    input  wire logic                  word_last_in,
    output logic                       word_ack,
    input  wire logic                  result_taken,
    output logic                       word_valid,
    output crc24_pkg::data_word_t      word_data,
    output logic                       word_last
);

    crc24_pkg::intake_state_t state;

    ///////////////////////////////
    // four-phase slave handshake
    ///////////////////////////////
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state      <= crc24_pkg::in_idle;
            word_ack   <= 1'b0;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            // default no new word
            word_valid <= 1'b0;
            case (state)
                crc24_pkg::in_idle: begin
                    if (word_req) begin
                        word_ack   <= 1'b1;
                        word_valid <= 1'b1;
                        word_last  <= word_last_in;
                        // a last word holds off the next burst
                        state      <= word_last_in ? crc24_pkg::in_blocked
                                                   : crc24_pkg::in_acked;
                    end
                end
                crc24_pkg::in_acked: begin
                    // wait for the host to drop req
                    if (!word_req) begin
                        word_ack <= 1'b0;
                        state    <= crc24_pkg::in_idle;
                    end
                end
                crc24_pkg::in_blocked: begin
                    // finish the pending handshake while blocked
                    if (!word_req) begin
                        word_ack <= 1'b0;
                    end
                    if (result_taken) begin
                        // req still high means ack has yet to fall
                        state <= (word_ack && word_req) ? crc24_pkg::in_acked
                                                        : crc24_pkg::in_idle;
                    end
                end
                default: begin
                    state    <= crc24_pkg::in_idle;
                    word_ack <= 1'b0;
                end
            endcase
        end
    end

    // data word is captured together with the ack
    always_ff @(posedge clk) begin
        if (state == crc24_pkg::in_idle && word_req) begin
            word_data <= word_data_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/crc24_word_evolve.sv
`timescale 1ns/1ns
`default_nettype none

module crc24_word_evolve (
    input  wire logic                  clk,
    input  wire logic                  arst,
    input  wire logic                  word_valid,
    input  wire crc24_pkg::data_word_t word_data,
    input  wire logic                  word_last,
    crc_window_if.producer             win
);

    // crc of one word from a zero state, msb first
    function automatic crc24_pkg::crc_t evolve_word(crc24_pkg::data_word_t w);
        crc24_pkg::crc_t s;
        s = '0;
        for (int i = crc24_pkg::WORD_W - 1; i >= 0; i--) begin
            s = crc24_pkg::crc_shift(s, w[i]);
        end
        return s;
    endfunction

    crc24_pkg::crc_t contrib;
    crc24_pkg::crc_t evo_q [crc24_pkg::MAX_WORDS];
    crc24_pkg::cover_t covered_q;
    logic in_burst;
    logic valid_q;

    // 64 levels of xor, flattened by synthesis
    assign contrib = evolve_word(word_data);

    ///////////////////////////////
    // burst window
    ///////////////////////////////
    // newest contribution enters at 0, older ones move up
    always_ff @(posedge clk) begin
        if (word_valid) begin
            evo_q[0] <= contrib;
            for (int k = 1; k < crc24_pkg::MAX_WORDS; k++) begin
                // first word of a burst drops any stale history
                evo_q[k] <= in_burst ? evo_q[k-1] : crc24_pkg::crc_t'(0);
            end
        end
    end

    // count of older words and the burst flag
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            covered_q <= '0;
            in_burst  <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= word_valid && word_last;
            if (word_valid) begin
                in_burst <= !word_last;
                if (!in_burst) begin
                    covered_q <= '0;
                end else if (covered_q != crc24_pkg::cover_t'(crc24_pkg::MAX_WORDS - 1)) begin
                    // saturate, longer bursts are undefined
                    covered_q <= covered_q + crc24_pkg::cover_t'(1);
                end
            end
        end
    end

    assign win.valid   = valid_q;
    assign win.covered = covered_q;
    assign win.evo     = evo_q;

endmodule

`default_nettype wire

// File: hdl/crc24_window_combine.sv
`timescale 1ns/1ns
`default_nettype none

module crc24_window_combine (
    input  wire logic         clk,
    input  wire logic         arst,
    crc_window_if.consumer    win,
    output crc24_pkg::crc_t   crc_value,
    output logic              crc_done
);

    localparam int HIST = crc24_pkg::MAX_WORDS - 1;

    // start value advanced by 1 to 6 words, constant after synthesis
    crc24_pkg::crc_t init_adv [crc24_pkg::MAX_WORDS];
    // history entry k advanced by k words
    crc24_pkg::crc_t hist_adv [HIST];

    ///////////////////////////////
    // zero-word advances
    ///////////////////////////////
    for (genvar g = 0; g < crc24_pkg::MAX_WORDS; g++) begin : g_init
        crc24_zero_advance #(.WORDS(g + 1)) u_init_adv (
            .state_in  (crc24_pkg::CRC_INIT),
            .state_out (init_adv[g])
        );
    end

    for (genvar g = 0; g < HIST; g++) begin : g_hist
        crc24_zero_advance #(.WORDS(g + 1)) u_hist_adv (
            .state_in  (win.evo[g+1]),
            .state_out (hist_adv[g])
        );
    end

    ///////////////////////////////
    // stage one, select terms
    ///////////////////////////////
    crc24_pkg::crc_t s1_new;
    crc24_pkg::crc_t s1_init;
    crc24_pkg::crc_t s1_hist [HIST];
    logic            s1_valid;

    always_ff @(posedge clk) begin
        if (win.valid) begin
            // newest word needs no advance
            s1_new  <= win.evo[0];
            // start value sits covered+1 words back
            s1_init <= init_adv[win.covered];
            for (int k = 0; k < HIST; k++) begin
                // only words of this burst count
                s1_hist[k] <= (crc24_pkg::cover_t'(k + 1) <= win.covered) ? hist_adv[k]
                                                                          : '0;
            end
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= win.valid;
        end
    end

    ///////////////////////////////
    // stage two, xor the terms
    ///////////////////////////////
    crc24_pkg::crc_t sum;

    always_comb begin
        sum = s1_new ^ s1_init;
        for (int k = 0; k < HIST; k++) begin
            sum = sum ^ s1_hist[k];
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            crc_value <= crc24_pkg::CRC_INIT;
            crc_done  <= 1'b0;
        end else begin
            crc_done <= s1_valid;
            if (s1_valid) begin
                crc_value <= sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/crc_result_port.sv
`timescale 1ns/1ns
`default_nettype none

module crc_result_port (
    input  wire logic            clk,
    input  wire logic            arst,
    input  wire crc24_pkg::crc_t crc_in,
    input  wire logic            crc_done,
    output logic                 crc_req,
    output crc24_pkg::crc_t      crc_value,
    input  wire logic            crc_ack,
    output logic                 result_taken
);

    crc24_pkg::result_state_t state;
    // a result arrived while the host still held ack
    logic held;

    ///////////////////////////////
    // result handshake
    ///////////////////////////////
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state        <= crc24_pkg::res_empty;
            crc_req      <= 1'b0;
            crc_value    <= crc24_pkg::CRC_INIT;
            result_taken <= 1'b0;
            held         <= 1'b0;
        end else begin
            result_taken <= 1'b0;
            // value must stay stable while offered
            if (crc_done && state != crc24_pkg::res_offered) begin
                crc_value <= crc_in;
            end
            case (state)
                crc24_pkg::res_empty: begin
                    if (crc_done) begin
                        crc_req <= 1'b1;
                        state   <= crc24_pkg::res_offered;
                    end
                end
                crc24_pkg::res_offered: begin
                    if (crc_ack) begin
                        result_taken <= 1'b1;
                        crc_req      <= 1'b0;
                        state        <= crc24_pkg::res_taken;
                    end
                end
                crc24_pkg::res_taken: begin
                    if (crc_done) begin
                        held <= 1'b1;
                    end
                    if (!crc_ack) begin
                        // offer a result that came in meanwhile
                        held    <= 1'b0;
                        crc_req <= held || crc_done;
                        state   <= (held || crc_done) ? crc24_pkg::res_offered
                                                      : crc24_pkg::res_empty;
                    end
                end
                default: begin
                    state   <= crc24_pkg::res_empty;
                    crc_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/crc24_burst_top.sv
`timescale 1ns/1ns
`default_nettype none

module crc24_burst_top (
    input  wire logic                  clk,
    input  wire logic                  arst,
    input  wire logic                  word_req,
    input  wire crc24_pkg::data_word_t word_data,
    input  wire logic                  word_last,
    output logic                       word_ack,
    output logic                       crc_req,
    output crc24_pkg::crc_t            crc_value,
    input  wire logic                  crc_ack
);

    // intake to evolver
    logic                  in_valid;
    crc24_pkg::data_word_t in_data;
    logic                  in_last;
    // combiner to result port
    crc24_pkg::crc_t       comb_crc;
    logic                  comb_done;
    // unblocks the intake
    logic                  result_taken;

    crc_window_if win ();

    burst_intake u_intake (
        .clk          (clk),
        .arst         (arst),
        .word_req     (word_req),
        .word_data_in (word_data),
        .word_last_in (word_last),
        .word_ack     (word_ack),
        .result_taken (result_taken),
        .word_valid   (in_valid),
        .word_data    (in_data),
        .word_last    (in_last)
    );

    crc24_word_evolve u_evolve (
        .clk        (clk),
        .arst       (arst),
        .word_valid (in_valid),
        .word_data  (in_data),
        .word_last  (in_last),
        .win        (win.producer)
    );

    crc24_window_combine u_combine (
        .clk       (clk),
        .arst      (arst),
        .win       (win.consumer),
        .crc_value (comb_crc),
        .crc_done  (comb_done)
    );

    crc_result_port u_result (
        .clk          (clk),
        .arst         (arst),
        .crc_in       (comb_crc),
        .crc_done     (comb_done),
        .crc_req      (crc_req),
        .crc_value    (crc_value),
        .crc_ack      (crc_ack),
        .result_taken (result_taken)
    );

endmodule

`default_nettype wire

// File: dv/crc24_ref.svh
`ifndef CRC24_REF_SVH
`define CRC24_REF_SVH

///////////////////////////////
// xorshift generator
///////////////////////////////
// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

///////////////////////////////
// bit-serial reference crc
///////////////////////////////
// poly 0x328B63, init all ones, msb first
// no reflection and no final inversion
function automatic crc24_pkg::crc_t burst_crc(
    input crc24_pkg::data_word_t words [crc24_pkg::MAX_WORDS],
    input int                    n
);
    crc24_pkg::crc_t s;
    logic            fb;
    s = crc24_pkg::CRC_INIT;
    for (int w = 0; w < n; w++) begin
        // one data bit per step, top bit of the word first
        for (int b = 63; b >= 0; b--) begin
            fb = s[23] ^ words[w][b];
            s  = {s[22:0], 1'b0};
            if (fb) begin
                s = s ^ crc24_pkg::CRC_POLY;
            end
        end
    end
    return s;
endfunction

`endif

// File: dv/crc24_burst_tb.sv
`timescale 1ns/1ns
`default_nettype none

module crc24_burst_tb;

    // burst counts per test phase
    localparam int N_SINGLE = 10;
    localparam int N_FULL   = 10;
    localparam int N_RANDOM = 100;
    localparam int BURSTS   = N_SINGLE + N_FULL + N_RANDOM;
    // under 110 cycles per burst worst case, so 160 leaves margin
    localparam int TIMEOUT_CYCLES = BURSTS * 160 + 800;

    logic                  clk = 1'b0;
    logic                  arst;
    logic                  word_req;
    crc24_pkg::data_word_t word_data;
    logic                  word_last;
    logic                  word_ack;
    logic                  crc_req;
    crc24_pkg::crc_t       crc_value;
    logic                  crc_ack;

    // expected results in burst order
    crc24_pkg::crc_t expected [$];
    int              results_seen = 0;
    int              cycles = 0;
    logic [31:0]     host_rng = 32'd44398;
    // second stream for the result side, same seed inverted
    logic [31:0]     ack_rng = ~32'd44398;
    logic            ack_prev = 1'b0;
    logic            blocked = 1'b0;

    `include "crc24_ref.svh"

    crc24_burst_top DUT (
        .clk       (clk),
        .arst      (arst),
        .word_req  (word_req),
        .word_data (word_data),
        .word_last (word_last),
        .word_ack  (word_ack),
        .crc_req   (crc_req),
        .crc_value (crc_value),
        .crc_ack   (crc_ack)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] next_host_rand();
        host_rng = xorshift32(host_rng);
        return host_rng;
    endfunction

    function automatic logic [31:0] next_ack_rand();
        ack_rng = xorshift32(ack_rng);
        return ack_rng;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    ///////////////////////////////
    // host side of the word port
    ///////////////////////////////
    // four-phase master, called on a rising edge with req and ack low
    task automatic send_word(input crc24_pkg::data_word_t d, input logic last);
        word_data <= d;
        word_last <= last;
        word_req  <= 1'b1;
        @(posedge clk);
        while (!word_ack) @(posedge clk);
        word_req <= 1'b0;
        @(posedge clk);
        while (word_ack) @(posedge clk);
    endtask

    // random words, expected crc queued before the first word goes out
    task automatic send_burst(input int n, input int max_gap);
        crc24_pkg::data_word_t words [crc24_pkg::MAX_WORDS];
        logic [31:0]           hi;
        logic [31:0]           lo;
        int                    gap;
        for (int i = 0; i < crc24_pkg::MAX_WORDS; i++) begin
            words[i] = '0;
        end
        for (int i = 0; i < n; i++) begin
            hi       = next_host_rand();
            lo       = next_host_rand();
            words[i] = {hi, lo};
        end
        expected.push_back(burst_crc(words, n));
        for (int i = 0; i < n; i++) begin
            send_word(words[i], i == n - 1);
            gap = int'(next_host_rand() % 32'(max_gap + 1));
            repeat (gap) @(posedge clk);
        end
    endtask

    initial begin
        int n;
        arst      = 1'b1;
        word_req  = 1'b0;
        word_data = '0;
        word_last = 1'b0;
        crc_ack   = 1'b0;
        repeat (4) @(posedge clk);
        arst <= 1'b0;
        repeat (2) @(posedge clk);
        assert (!word_ack && !crc_req)
            else fail_now("word_ack or crc_req high after reset before any request");
        // start value term alone
        for (int b = 0; b < N_SINGLE; b++) begin
            send_burst(1, 3);
        end
        // every history term and advance depth
        for (int b = 0; b < N_FULL; b++) begin
            send_burst(crc24_pkg::MAX_WORDS, 3);
        end
        // mixed lengths and gaps
        for (int b = 0; b < N_RANDOM; b++) begin
            n = 1 + int'(next_host_rand() % 32'(crc24_pkg::MAX_WORDS));
            send_burst(n, 7);
        end
        while (results_seen < BURSTS) @(posedge clk);
        // longest ack hold plus the handshake, so a repeated offer reaches the checker
        repeat (64) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

    ///////////////////////////////
    // result side and checker
    ///////////////////////////////
    initial begin
        crc24_pkg::crc_t want;
        int              hold;
        forever begin
            @(posedge clk);
            if (crc_req) begin
                assert (expected.size() > 0)
                    else fail_now("crc_req raised with no burst outstanding");
                want = expected.pop_front();
                assert (crc_value == want)
                    else fail_now($sformatf(
                        "Mismatch at time %0t: crc_value got 24'h%06h, expected 24'h%06h",
                        $time, crc_value, want));
                results_seen++;
                // hold ack back to stall the next burst
                hold = int'(next_ack_rand() % 32);
                repeat (hold) @(posedge clk);
                crc_ack <= 1'b1;
                @(posedge clk);
                while (crc_req) @(posedge clk);
                crc_ack <= 1'b0;
            end
        end
    end

    // no word_ack for a new burst until the host has raised crc_ack
    always @(posedge clk) begin
        if (crc_ack) begin
            blocked = 1'b0;
        end
        if (word_ack && !ack_prev) begin
            assert (!blocked)
                else fail_now("word_ack rose for a new burst before crc_ack was raised");
            if (word_last) begin
                blocked = 1'b1;
            end
        end
        ack_prev = word_ack;
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout after %0d cycles with %0d of %0d results seen",
                               cycles, results_seen, BURSTS));
        end
    end

endmodule

`default_nettype wire

// File: crc24_burst_top.f
+incdir+dv
hdl/crc24_pkg.sv
hdl/crc_window_if.sv
hdl/crc24_zero_advance.sv
hdl/burst_intake.sv
hdl/crc24_word_evolve.sv
hdl/crc24_window_combine.sv
hdl/crc_result_port.sv
hdl/crc24_burst_top.sv
dv/crc24_burst_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the crc24 burst testbench with Verilator and runs it
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module crc24_burst_tb \
    -f crc24_burst_top.f \
    -o sim_crc24_burst
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_crc24_burst
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0
